// File: slc3_settings.svh
// Build-wide constants; SLC3_MEM_WAIT must be at least 2, the SRAM answers within it
`ifndef SLC3_SETTINGS_SVH
`define SLC3_SETTINGS_SVH

// ------------------------------
// Memory map
// ------------------------------
// Single mapped word: switches on read, hex register on write
`define SLC3_IO_ADDR 16'hFFFF

// PC value after reset
`define SLC3_RESET_PC 16'h0000

// ------------------------------
// Timing
// ------------------------------
// Read states with OE held low
`define SLC3_MEM_WAIT 2
// Flops in each button synchronizer
`define SLC3_SYNC_STAGES 2

`endif

// File: slc3Pkg.sv
// Types shared by control and datapath; only the kept LC-3 subset has opcode values
package slc3Pkg;

    // Instruction opcodes in ir[15:12]
    typedef enum logic [3:0] {
        BR    = 4'b0000,
        ADD   = 4'b0001,
        JSR   = 4'b0100,
        AND   = 4'b0101,
        LDR   = 4'b0110,
        STR   = 4'b0111,
        NOT   = 4'b1001,
        JMP   = 4'b1100,
        PAUSE = 4'b1101
    } slc3Opcode;

    // Controller states
    typedef enum logic [4:0] {
        Halted, FetchMar, FetchRead1, FetchRead2, FetchIr, Decode,
        ExecAdd, ExecAnd, ExecNot, BrTest, JmpLoad, JsrLink,
        LdrAddr, LdrRead1, LdrRead2, LdrLoad,
        StrAddr, StrData, StrWrite,
        PauseWaitPress, PauseWaitRelease
    } ctrlState;

    // ALU function select
    typedef enum logic [1:0] {
        Add   = 2'd0,
        And   = 2'd1,
        NotA  = 2'd2,
        PassA = 2'd3
    } aluOp;

endpackage

// File: memIo.sv
// SRAM word access only (no byte lanes); one I/O word at SLC3_IO_ADDR, no wait handshake
`include "slc3_settings.svh"

module memIo (
    input  logic        Clk,
    input  logic        rstN,
    input  logic [15:0] mar,
    input  logic [15:0] mdr,
    input  logic        memRead,
    input  logic        memWrite,
    input  logic [15:0] switches,
    output logic [15:0] memData,
    output logic [15:0] hexValue,
    output logic [19:0] ADDR,
    output logic        CE,
    output logic        UB,
    output logic        LB,
    output logic        OE,
    output logic        WE,
    inout  wire  [15:0] Data
);

    logic isIo;
    logic sramAccess;

    // ------------------------------
    // Address decode and strobes
    // ------------------------------
    assign isIo = (mar == `SLC3_IO_ADDR);
    // SRAM stays deselected for the mapped word
    assign sramAccess = (memRead | memWrite) & ~isIo;

    // 64K space on a 1M part, upper bits tied low
    assign ADDR = {4'h0, mar};
    assign CE = ~sramAccess;
    // Both byte lanes follow chip enable
    assign UB = ~sramAccess;
    assign LB = ~sramAccess;
    assign OE = ~(memRead & ~isIo);
    assign WE = ~(memWrite & ~isIo);

    // ------------------------------
    // Data bus
    // ------------------------------
    // Drive only during a write
    assign Data = WE ? 16'hzzzz : mdr;

    // Switches replace SRAM data at the I/O word
    assign memData = isIo ? switches : Data;

    // Hex register, loaded on a write to the I/O word
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            hexValue <= 16'h0000;
        end else if (memWrite && isIo) begin
            hexValue <= mdr;
        end
    end

    // SRAM never sees read and write together
    oeWeExclusive: assert property (@(posedge Clk) disable iff (!rstN) !(!OE && !WE))
        else $error("OE and WE low together");

endmodule

// File: controlUnit.sv
// Moore sequencer, one instruction at a time; run and resume are raw active-low buttons
`include "slc3_settings.svh"

module controlUnit import slc3Pkg::*; (
    input  logic        Clk,
    input  logic        rstN,
    input  logic        run,
    input  logic        resume,
    input  logic [15:0] ir,
    input  logic        ben,
    output logic        ldMar,
    output logic        ldMdr,
    output logic        ldIr,
    output logic        ldCc,
    output logic        ldReg,
    output logic        ldPc,
    output logic        ldLed,
    output logic        gatePc,
    output logic        gateMdr,
    output logic        gateAlu,
    output logic        gateAddr,
    output logic        pcSel,
    output logic        addr1Sel,
    output logic [1:0]  addr2Sel,
    output logic        sr1Sel,
    output logic        drSel,
    output logic        sr2Sel,
    output aluOp        aluFn,
    output logic        mioEn,
    output logic        memRead,
    output logic        memWrite
);

    // Address adder offset selects
    localparam logic [1:0] Off0  = 2'd0;
    localparam logic [1:0] Off6  = 2'd1;
    localparam logic [1:0] Off9  = 2'd2;
    localparam logic [1:0] Off11 = 2'd3;
    // Read1 repeats until this count, Read2 is the last read state
    localparam logic [3:0] LastWait = 4'(`SLC3_MEM_WAIT - 2);

    ctrlState  state;
    ctrlState  nextState;
    slc3Opcode opcode;
    logic [`SLC3_SYNC_STAGES-1:0] runSync;
    logic [`SLC3_SYNC_STAGES-1:0] resumeSync;
    logic       runPressed;
    logic       resumePressed;
    logic [3:0] readWait;
    logic       readDone;

    // ------------------------------
    // Button synchronizers
    // ------------------------------
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            runSync    <= '1;
            resumeSync <= '1;
        end else begin
            runSync    <= {runSync[`SLC3_SYNC_STAGES-2:0], run};
            resumeSync <= {resumeSync[`SLC3_SYNC_STAGES-2:0], resume};
        end
    end

    // Active low at the pins
    assign runPressed    = ~runSync[`SLC3_SYNC_STAGES-1];
    assign resumePressed = ~resumeSync[`SLC3_SYNC_STAGES-1];

    assign opcode   = slc3Opcode'(ir[15:12]);
    assign readDone = (readWait == LastWait);

    // ------------------------------
    // State register
    // ------------------------------
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            state    <= Halted;
            readWait <= '0;
        end else begin
            state <= nextState;
            // Counts repeats of the first read state
            if (state == FetchRead1 || state == LdrRead1) begin
                readWait <= readWait + 4'd1;
            end else begin
                readWait <= '0;
            end
        end
    end

    always_comb begin
        nextState = state;
        case (state)
            Halted:     if (runPressed) nextState = FetchMar;
            FetchMar:   nextState = FetchRead1;
            FetchRead1: if (readDone) nextState = FetchRead2;
            FetchRead2: nextState = FetchIr;
            FetchIr:    nextState = Decode;
            Decode: begin
                case (opcode)
                    ADD:     nextState = ExecAdd;
                    AND:     nextState = ExecAnd;
                    NOT:     nextState = ExecNot;
                    BR:      nextState = BrTest;
                    JMP:     nextState = JmpLoad;
                    JSR:     nextState = JsrLink;
                    LDR:     nextState = LdrAddr;
                    STR:     nextState = StrAddr;
                    PAUSE:   nextState = PauseWaitPress;
                    // Unsupported opcodes are skipped
                    default: nextState = FetchMar;
                endcase
            end
            LdrAddr:  nextState = LdrRead1;
            LdrRead1: if (readDone) nextState = LdrRead2;
            LdrRead2: nextState = LdrLoad;
            StrAddr:  nextState = StrData;
            StrData:  nextState = StrWrite;
            PauseWaitPress:   if (resumePressed) nextState = PauseWaitRelease;
            PauseWaitRelease: if (!resumePressed) nextState = FetchMar;
            // Single-cycle executes, LdrLoad and StrWrite
            default:  nextState = FetchMar;
        endcase
    end

    // ------------------------------
    // Output decode
    // ------------------------------
    always_comb begin
        ldMar    = 1'b0;
        ldMdr    = 1'b0;
        ldIr     = 1'b0;
        ldCc     = 1'b0;
        ldReg    = 1'b0;
        ldPc     = 1'b0;
        ldLed    = 1'b0;
        gatePc   = 1'b0;
        gateMdr  = 1'b0;
        gateAlu  = 1'b0;
        gateAddr = 1'b0;
        pcSel    = 1'b0;
        addr1Sel = 1'b0;
        addr2Sel = Off0;
        sr1Sel   = 1'b0;
        drSel    = 1'b0;
        // Immediate form flag
        sr2Sel   = ir[5];
        aluFn    = PassA;
        mioEn    = 1'b0;
        memRead  = 1'b0;
        memWrite = 1'b0;
        case (state)
            FetchMar: begin
                gatePc = 1'b1;
                ldMar  = 1'b1;
                // PC + 1
                ldPc   = 1'b1;
            end
            FetchRead1, LdrRead1: memRead = 1'b1;
            FetchRead2, LdrRead2: begin
                memRead = 1'b1;
                mioEn   = 1'b1;
                ldMdr   = 1'b1;
            end
            FetchIr: begin
                gateMdr = 1'b1;
                ldIr    = 1'b1;
            end
            ExecAdd, ExecAnd, ExecNot: begin
                sr1Sel  = 1'b1;
                gateAlu = 1'b1;
                ldReg   = 1'b1;
                ldCc    = 1'b1;
                aluFn   = (state == ExecAdd) ? Add : (state == ExecAnd) ? And : NotA;
            end
            BrTest: begin
                // PC + offset9 when a flag matches
                ldPc     = ben;
                pcSel    = 1'b1;
                addr2Sel = Off9;
            end
            JmpLoad: begin
                // BaseR + 0
                ldPc     = 1'b1;
                pcSel    = 1'b1;
                sr1Sel   = 1'b1;
                addr1Sel = 1'b1;
                addr2Sel = Off0;
            end
            JsrLink: begin
                // R7 takes the old PC on the bus while PC jumps
                gatePc   = 1'b1;
                drSel    = 1'b1;
                ldReg    = 1'b1;
                ldPc     = 1'b1;
                pcSel    = 1'b1;
                addr2Sel = Off11;
            end
            LdrAddr, StrAddr: begin
                sr1Sel   = 1'b1;
                addr1Sel = 1'b1;
                addr2Sel = Off6;
                gateAddr = 1'b1;
                ldMar    = 1'b1;
            end
            LdrLoad: begin
                gateMdr = 1'b1;
                ldReg   = 1'b1;
                ldCc    = 1'b1;
            end
            StrData: begin
                // Source register passes through the ALU into MDR
                gateAlu = 1'b1;
                ldMdr   = 1'b1;
            end
            StrWrite:       memWrite = 1'b1;
            PauseWaitPress: ldLed = 1'b1;
            default: ;
        endcase
    end

    atMostOneGate: assert property (@(posedge Clk) disable iff (!rstN)
        $onehot0({gatePc, gateMdr, gateAlu, gateAddr}))
        else $error("Several bus gates active");

endmodule

// File: datapath.sv
// Registers, ALU and address adder; register file and IR come up unknown after reset
`include "slc3_settings.svh"

module datapath import slc3Pkg::*; (
    input  logic        Clk,
    input  logic        rstN,
    input  logic        ldMar,
    input  logic        ldMdr,
    input  logic        ldIr,
    input  logic        ldCc,
    input  logic        ldReg,
    input  logic        ldPc,
    input  logic        ldLed,
    input  logic        gatePc,
    input  logic        gateMdr,
    input  logic        gateAlu,
    input  logic        gateAddr,
    input  logic        pcSel,
    input  logic        addr1Sel,
    input  logic [1:0]  addr2Sel,
    input  logic        sr1Sel,
    input  logic        drSel,
    input  logic        sr2Sel,
    input  aluOp        aluFn,
    input  logic        mioEn,
    input  logic [15:0] memData,
    output logic [15:0] pc,
    output logic [15:0] mar,
    output logic [15:0] mdr,
    output logic [15:0] ir,
    output logic        ben,
    output logic [11:0] led
);

    logic [15:0] regFile [8];
    logic [15:0] bus;
    logic [15:0] sr1Out;
    logic [15:0] sr2Out;
    logic [15:0] aluB;
    logic [15:0] aluOut;
    logic [15:0] addr1;
    logic [15:0] addr2;
    logic [15:0] addrSum;
    logic [2:0]  sr1Idx;
    logic [2:0]  drIdx;
    logic [2:0]  nzp;

    // ------------------------------
    // Bus
    // ------------------------------
    always_comb begin
        case ({gatePc, gateMdr, gateAlu, gateAddr})
            4'b1000: bus = pc;
            4'b0100: bus = mdr;
            4'b0010: bus = aluOut;
            4'b0001: bus = addrSum;
            default: bus = 16'h0000;
        endcase
    end

    // ------------------------------
    // Register file
    // ------------------------------
    // SR1 is ir[11:9] or BaseR/SR1 in ir[8:6]
    assign sr1Idx = sr1Sel ? ir[8:6] : ir[11:9];
    // DR is ir[11:9] or R7 for JSR
    assign drIdx  = drSel ? 3'd7 : ir[11:9];
    assign sr1Out = regFile[sr1Idx];
    assign sr2Out = regFile[ir[2:0]];

    always_ff @(posedge Clk) begin
        if (ldReg) begin
            regFile[drIdx] <= bus;
        end
    end

    // ALU, imm5 or SR2 as second operand
    assign aluB = sr2Sel ? {{11{ir[4]}}, ir[4:0]} : sr2Out;

    always_comb begin
        case (aluFn)
            Add:     aluOut = sr1Out + aluB;
            And:     aluOut = sr1Out & aluB;
            NotA:    aluOut = ~sr1Out;
            default: aluOut = sr1Out;
        endcase
    end

    // ------------------------------
    // Address adder
    // ------------------------------
    assign addr1 = addr1Sel ? sr1Out : pc;

    always_comb begin
        case (addr2Sel)
            2'd1:    addr2 = {{10{ir[5]}}, ir[5:0]};
            2'd2:    addr2 = {{7{ir[8]}}, ir[8:0]};
            2'd3:    addr2 = {{5{ir[10]}}, ir[10:0]};
            default: addr2 = 16'h0000;
        endcase
    end

    assign addrSum = addr1 + addr2;

    // ------------------------------
    // Control registers
    // ------------------------------
    always_ff @(posedge Clk or negedge rstN) begin
        if (!rstN) begin
            pc  <= `SLC3_RESET_PC;
            nzp <= 3'b000;
            led <= 12'h000;
        end else begin
            // Increment or jump target
            if (ldPc) begin
                pc <= pcSel ? addrSum : pc + 16'h0001;
            end
            if (ldCc) begin
                nzp <= {bus[15], bus == 16'h0000, ~bus[15] && bus != 16'h0000};
            end
            // Pause code
            if (ldLed) begin
                led <= ir[11:0];
            end
        end
    end

    // Payload registers
    always_ff @(posedge Clk) begin
        if (ldMar) begin
            mar <= bus;
        end
        // Memory read or bus
        if (ldMdr) begin
            mdr <= mioEn ? memData : bus;
        end
        if (ldIr) begin
            ir <= bus;
        end
    end

    // Any flag named in the BR instruction
    assign ben = |(ir[11:9] & nzp);

    // A register loaded from the bus sees exactly one source
    busSourced: assert property (@(posedge Clk) disable iff (!rstN)
        (ldMar || ldIr || ldReg || ldCc) |-> $onehot({gatePc, gateMdr, gateAlu, gateAddr}))
        else $error("Bus load without a single driver");

endmodule

// File: hexDisplay.sv
// Four seven-segment digits, active-low segments in gfedcba order
module hexDisplay (
    input  logic [15:0] value,
    output logic [6:0]  seg0,
    output logic [6:0]  seg1,
    output logic [6:0]  seg2,
    output logic [6:0]  seg3
);

    function automatic logic [6:0] segOf(input logic [3:0] nibble);
        case (nibble)
            4'h0:    return 7'b1000000;
            4'h1:    return 7'b1111001;
            4'h2:    return 7'b0100100;
            4'h3:    return 7'b0110000;
            4'h4:    return 7'b0011001;
            4'h5:    return 7'b0010010;
            4'h6:    return 7'b0000010;
            4'h7:    return 7'b1111000;
            4'h8:    return 7'b0000000;
            4'h9:    return 7'b0010000;
            4'hA:    return 7'b0001000;
            // Lower-case b and d
            4'hB:    return 7'b0000011;
            4'hC:    return 7'b1000110;
            4'hD:    return 7'b0100001;
            4'hE:    return 7'b0000110;
            default: return 7'b0001110;
        endcase
    endfunction

    // seg0 is the least significant digit
    assign seg0 = segOf(value[3:0]);
    assign seg1 = segOf(value[7:4]);
    assign seg2 = segOf(value[11:8]);
    assign seg3 = segOf(value[15:12]);

endmodule

// File: slc3.sv
// SLC-3 top; run and resume are undebounced active-low buttons, SRAM on a shared bus
module slc3 import slc3Pkg::*; (
    input  logic        Clk,
    input  logic        rstN,
    input  logic        run,
    input  logic        resume,
    input  logic [15:0] switches,
    output logic [11:0] LED,
    output logic [6:0]  HEX0,
    output logic [6:0]  HEX1,
    output logic [6:0]  HEX2,
    output logic [6:0]  HEX3,
    output logic [6:0]  HEX4,
    output logic [6:0]  HEX5,
    output logic [6:0]  HEX6,
    output logic [6:0]  HEX7,
    output logic        CE,
    output logic        UB,
    output logic        LB,
    output logic        OE,
    output logic        WE,
    output logic [19:0] ADDR,
    inout  wire  [15:0] Data
);

    // ------------------------------
    // Control strobes
    // ------------------------------
    logic ldMar, ldMdr, ldIr, ldCc, ldReg, ldPc, ldLed;
    logic gatePc, gateMdr, gateAlu, gateAddr;
    logic pcSel, addr1Sel, sr1Sel, drSel, sr2Sel;
    logic [1:0] addr2Sel;
    aluOp aluFn;
    logic mioEn, memRead, memWrite;

    // Datapath and memory values
    logic [15:0] pc, mar, mdr, ir, memData, hexValue;
    logic        ben;

    memIo memUnit (
        .Clk, .rstN, .mar, .mdr, .memRead, .memWrite, .switches,
        .memData, .hexValue, .ADDR, .CE, .UB, .LB, .OE, .WE, .Data
    );

    controlUnit control (
        .Clk, .rstN, .run, .resume, .ir, .ben,
        .ldMar, .ldMdr, .ldIr, .ldCc, .ldReg, .ldPc, .ldLed,
        .gatePc, .gateMdr, .gateAlu, .gateAddr,
        .pcSel, .addr1Sel, .addr2Sel, .sr1Sel, .drSel, .sr2Sel,
        .aluFn, .mioEn, .memRead, .memWrite
    );

    datapath dpath (
        .Clk, .rstN,
        .ldMar, .ldMdr, .ldIr, .ldCc, .ldReg, .ldPc, .ldLed,
        .gatePc, .gateMdr, .gateAlu, .gateAddr,
        .pcSel, .addr1Sel, .addr2Sel, .sr1Sel, .drSel, .sr2Sel,
        .aluFn, .mioEn, .memData,
        .pc, .mar, .mdr, .ir, .ben, .led(LED)
    );

    // PC on the upper four digits
    hexDisplay pcDisplay (
        .value(pc), .seg0(HEX4), .seg1(HEX5), .seg2(HEX6), .seg3(HEX7)
    );

    // I/O hex register on the lower four
    hexDisplay ioDisplay (
        .value(hexValue), .seg0(HEX0), .seg1(HEX1), .seg2(HEX2), .seg3(HEX3)
    );

endmodule

// File: tbSram.sv
// Behavioral 64K x16 async SRAM; byte lanes ignored, ADDR[19:16] unused, no timing checks
module tbSram (
    input  logic [19:0] ADDR,
    input  logic        CE,
    input  logic        OE,
    input  logic        WE,
    inout  wire  [15:0] Data
);
    timeunit 1ns;
    timeprecision 100ps;

    logic [15:0] mem [65536];

    // ------------------------------
    // Bus side
    // ------------------------------
    // Read drives the bus only with WE high
    assign Data = (!CE && !OE && WE) ? mem[ADDR[15:0]] : 16'hzzzz;

    // Level-sensitive write while CE and WE are low
    always @(CE or WE or ADDR or Data) begin
        if (!CE && !WE) begin
            mem[ADDR[15:0]] = Data;
        end
    end

    // ------------------------------
    // Backdoor access
    // ------------------------------
    // Byte-swapped address mixed with a constant
    task fillPattern();
        for (int a = 0; a < 65536; a++) begin
            mem[a] = {a[7:0], a[15:8]} ^ 16'h5A5A;
        end
    endtask

    task writeWord(input logic [15:0] addr, input logic [15:0] value);
        mem[addr] = value;
    endtask

    function logic [15:0] readWord(input logic [15:0] addr);
        return mem[addr];
    endfunction

endmodule

// File: tbSlc3.sv
// Program must sit at SLC3_RESET_PC with R0 cleared first; scratch word at 16'h0040
`include "slc3_settings.svh"

module tbSlc3 import slc3Pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int NumRows     = 8;
    localparam int ResetCycles = 5;
    // Per-row bound grows with the read wait states
    localparam int RowBound    = 100 * `SLC3_MEM_WAIT;
    localparam int CycleLimit  = NumRows * RowBound + ResetCycles;
    // PC seen at each pause is the PAUSE address plus 1
    localparam logic [15:0] ReadyPc = `SLC3_RESET_PC + 16'd3;
    localparam logic [15:0] PosPc   = `SLC3_RESET_PC + 16'd11;
    localparam logic [15:0] NegPc   = `SLC3_RESET_PC + 16'd14;
    localparam logic [15:0] ScratchAddr = 16'h0040;

    logic        Clk;
    logic        rstN;
    logic        run;
    logic        resume;
    logic [15:0] switches;
    logic [11:0] LED;
    logic [6:0]  HEX0, HEX1, HEX2, HEX3, HEX4, HEX5, HEX6, HEX7;
    logic        CE, UB, LB, OE, WE;
    logic [19:0] ADDR;
    wire  [15:0] Data;

    // Stimulus and expectation table
    logic [15:0] rowSwitch [NumRows];
    logic [11:0] rowCode [NumRows];
    logic [15:0] rowHex [NumRows];
    logic [15:0] rowWord [NumRows];

    integer seed;
    int errors = 0;
    int checks = 0;
    int cycles = 0;

    slc3 dut (
        .Clk, .rstN, .run, .resume, .switches, .LED,
        .HEX0, .HEX1, .HEX2, .HEX3, .HEX4, .HEX5, .HEX6, .HEX7,
        .CE, .UB, .LB, .OE, .WE, .ADDR, .Data
    );

    tbSram sram (.ADDR, .CE, .OE, .WE, .Data);

    initial begin
        Clk = 1'b0;
        forever #5 Clk = ~Clk;
    end

    // Watchdog
    always @(posedge Clk) begin
        cycles <= cycles + 1;
        if (cycles >= CycleLimit) begin
            $display("Timeout after %0d cycles, the expected pause never came", cycles);
            $display("Checks failed");
            $finish;
        end
    end

    // ------------------------------
    // Compare tasks
    // ------------------------------
    task checkWord(input logic [15:0] got, input logic [15:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task checkCode(input logic [11:0] got, input logic [11:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    task checkSeg(input logic [6:0] got, input logic [6:0] exp, input string what);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Error at %0t: %s got %b expected %b", $time, what, got, exp);
        end
    endtask

    // Word access enables both byte lanes, 64K space keeps ADDR[19:16] at zero
    always @(negedge Clk) begin
        if (rstN && !CE) begin
            checkWord({10'h000, ADDR[19:16], UB, LB}, 16'h0000, "byte lanes and upper address");
        end
    end

    // Active-low gfedcba pattern of one hex digit
    function automatic logic [6:0] segFor(input logic [3:0] n);
        logic [6:0] lit [16];
        lit = '{7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D, 7'h7D, 7'h07,
                7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71};
        return ~lit[n];
    endfunction

    task checkDigits(input logic [15:0] value, input logic [6:0] d3, input logic [6:0] d2,
                     input logic [6:0] d1, input logic [6:0] d0, input string what);
        checkSeg(d3, segFor(value[15:12]), {what, " digit 3"});
        checkSeg(d2, segFor(value[11:8]), {what, " digit 2"});
        checkSeg(d1, segFor(value[7:4]), {what, " digit 1"});
        checkSeg(d0, segFor(value[3:0]), {what, " digit 0"});
    endtask

    // ------------------------------
    // Instruction encoders
    // ------------------------------
    function automatic logic [15:0] encAluImm(input slc3Opcode op, input logic [2:0] dr,
                                              input logic [2:0] sr1, input logic [4:0] imm);
        return {op, dr, sr1, 1'b1, imm};
    endfunction

    function automatic logic [15:0] encAluReg(input slc3Opcode op, input logic [2:0] dr,
                                              input logic [2:0] sr1, input logic [2:0] sr2);
        return {op, dr, sr1, 3'b000, sr2};
    endfunction

    // LDR and STR share one layout
    function automatic logic [15:0] encMem(input slc3Opcode op, input logic [2:0] r,
                                           input logic [2:0] base, input logic [5:0] off);
        return {op, r, base, off};
    endfunction

    function automatic logic [15:0] encBr(input logic [2:0] nzp, input logic [8:0] off);
        return {BR, nzp, off};
    endfunction

    // ------------------------------
    // Program and table
    // ------------------------------
    task loadProgram();
        logic [15:0] prog [21];
        prog[0]  = encAluImm(AND, 3'd0, 3'd0, 5'd0);
        // R5 gets the scratch address from the data word at 20
        prog[1]  = encMem(LDR, 3'd5, 3'd0, 6'd20);
        prog[2]  = {PAUSE, 12'h0FF};
        // R0 minus 1 reaches the I/O word
        prog[3]  = encMem(LDR, 3'd1, 3'd0, 6'h3F);
        prog[4]  = encAluImm(ADD, 3'd3, 3'd1, 5'd5);
        prog[5]  = {NOT, 3'd4, 3'd1, 6'h3F};
        prog[6]  = encAluReg(AND, 3'd3, 3'd3, 3'd4);
        prog[7]  = encMem(STR, 3'd3, 3'd0, 6'h3F);
        prog[8]  = encAluImm(ADD, 3'd1, 3'd1, 5'd0);
        prog[9]  = encBr(3'b100, 9'd3);
        prog[10] = {PAUSE, 12'h002};
        prog[11] = {JSR, 1'b1, 11'd4};
        // Back to 2 with offsets -11 and -14
        prog[12] = encBr(3'b111, 9'h1F5);
        prog[13] = {PAUSE, 12'h001};
        prog[14] = {JSR, 1'b1, 11'd1};
        prog[15] = encBr(3'b111, 9'h1F2);
        // Subroutine stores S, reads it back and echoes it to the hex register
        prog[16] = encMem(STR, 3'd1, 3'd5, 6'd0);
        prog[17] = encMem(LDR, 3'd2, 3'd5, 6'd0);
        prog[18] = encMem(STR, 3'd2, 3'd0, 6'h3F);
        prog[19] = {JMP, 3'b000, 3'd7, 6'd0};
        prog[20] = ScratchAddr;
        sram.fillPattern();
        for (int i = 0; i < 21; i++) begin
            sram.writeWord(`SLC3_RESET_PC + 16'(i), prog[i]);
        end
    endtask

    task buildTable();
        for (int i = 0; i < NumRows; i++) begin
            rowSwitch[i] = 16'($random(seed));
        end
        // Sign boundary and zero
        rowSwitch[NumRows-2] = 16'h8000;
        rowSwitch[NumRows-1] = 16'h0000;
        for (int i = 0; i < NumRows; i++) begin
            rowCode[i] = rowSwitch[i][15] ? 12'h001 : 12'h002;
            rowHex[i]  = (rowSwitch[i] + 16'd5) & ~rowSwitch[i];
            rowWord[i] = rowSwitch[i];
        end
    endtask

    // Hold a button low for a few cycles
    task pressButton(input logic useRun);
        @(negedge Clk);
        if (useRun) run = 1'b0;
        else resume = 1'b0;
        repeat (4) @(negedge Clk);
        run = 1'b1;
        resume = 1'b1;
    endtask

    task waitLedChange(input logic [11:0] prev);
        do begin
            @(negedge Clk);
        end while (LED == prev);
    endtask

    // ------------------------------
    // Main sequence
    // ------------------------------
    initial begin
        logic [15:0] ioWord;
        logic [15:0] codePc;
        rstN = 1'b0;
        run = 1'b1;
        resume = 1'b1;
        switches = 16'h0000;
        seed = 32'h30fdfce8;
        buildTable();
        loadProgram();
        ioWord = sram.readWord(`SLC3_IO_ADDR);

        repeat (ResetCycles - 1) @(negedge Clk);
        checkWord({11'h000, CE, UB, LB, OE, WE}, 16'h001F, "CE UB LB OE WE in reset");
        checkCode(LED, 12'h000, "LED in reset");
        checkDigits(`SLC3_RESET_PC, HEX7, HEX6, HEX5, HEX4, "PC in reset");
        @(negedge Clk);
        rstN = 1'b1;
        @(negedge Clk);
        checkWord({11'h000, CE, UB, LB, OE, WE}, 16'h001F, "CE UB LB OE WE after reset");
        checkCode(LED, 12'h000, "LED after reset");
        checkDigits(`SLC3_RESET_PC, HEX7, HEX6, HEX5, HEX4, "PC after reset");

        // Start and reach the ready pause
        pressButton(1'b1);
        waitLedChange(12'h000);
        checkCode(LED, 12'h0FF, "ready pause code");
        checkDigits(ReadyPc, HEX7, HEX6, HEX5, HEX4, "PC at ready pause");

        for (int i = 0; i < NumRows; i++) begin
            @(negedge Clk);
            switches = rowSwitch[i];
            pressButton(1'b0);
            waitLedChange(12'h0FF);
            codePc = rowSwitch[i][15] ? NegPc : PosPc;
            checkCode(LED, rowCode[i], "branch pause code");
            checkDigits(rowHex[i], HEX3, HEX2, HEX1, HEX0, "ALU result on hex");
            checkDigits(codePc, HEX7, HEX6, HEX5, HEX4, "PC at branch pause");

            // Subroutine runs and returns to the ready pause
            pressButton(1'b0);
            waitLedChange(rowCode[i]);
            checkCode(LED, 12'h0FF, "ready pause code");
            checkDigits(rowSwitch[i], HEX3, HEX2, HEX1, HEX0, "switch echo on hex");
            checkDigits(ReadyPc, HEX7, HEX6, HEX5, HEX4, "PC at ready pause");
            checkWord(sram.readWord(ScratchAddr), rowWord[i], "SRAM scratch word");
            checkWord(sram.readWord(`SLC3_IO_ADDR), ioWord, "SRAM word at I/O address");
        end

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// File: list.f
+incdir+.
slc3Pkg.sv
memIo.sv
controlUnit.sv
datapath.sv
hexDisplay.sv
slc3.sv
tbSram.sv
tbSlc3.sv

// File: Makefile
# Verilator flow for the SLC-3 testbench

SIM = obj_dir/VtbSlc3

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --timescale 1ns/100ps -f list.f --top-module tbSlc3 -o VtbSlc3

run: compile
	$(SIM) | tee run.log
	grep -q "All checks passed" run.log

clean:
	rm -rf obj_dir run.log
